// ==== common/sysctl_config.svh ====
`ifndef SYSCTL_CONFIG_SVH
`define SYSCTL_CONFIG_SVH

// --------------------
// bus geometry
// --------------------

// register bus data width
`define SYSCTL_DW 8

// --------------------
// reset generator
// --------------------

// stretched pulse length in clocks, two or more
`define SYSCTL_RESET_CYCLES 4

// value returned by the id register at address 1
`define SYSCTL_ID 8'hA5

`endif

// ==== common/sysctl_pkg.sv ====
`default_nettype none

package sysctl_pkg;

   // --------------------
   // address map
   // --------------------

   // one register per address, four in total
   typedef enum logic [1:0] {
      // reset generator, write arms, read gives reset_o
      ADDR_RESET  = 2'd0,
      // read-only identification byte
      ADDR_ID     = 2'd1,
      // counter low byte, read also snapshots the high byte
      ADDR_CNT_LO = 2'd2,
      // counter high byte from the snapshot
      ADDR_CNT_HI = 2'd3
   } reg_addr_t;

   // --------------------
   // register layout
   // --------------------

   // arming bit on write, reset state on read
   localparam int RESET_BIT = 0;

   // free-running counter width
   // spans two bus bytes
   localparam int CNT_W = 16;

endpackage

`default_nettype wire

// ==== common/wb_slave_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sysctl_config.svh"

// one slave port of the register bus
interface wb_slave_if #(
   parameter int DW = `SYSCTL_DW
);

   // strobe, already qualified by cyc and address
   logic          stb;
   logic          we;
   logic [DW-1:0] wdat;
   logic [DW-1:0] rdat;
   // one-cycle acknowledge from the slave
   logic          ack;

   // decoder side
   modport master (
      output stb,
      output we,
      output wdat,
      input  rdat,
      input  ack
   );

   // register block side
   modport slave (
      input  stb,
      input  we,
      input  wdat,
      output rdat,
      output ack
   );

endinterface

`default_nettype wire

// ==== hw/sysctl_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sysctl_config.svh"

module sysctl_decoder (
   input  wire                    clk_i,
   input  wire                    rst_i,
   // bus from the master
   input  wire                    cyc_i,
   input  wire                    stb_i,
   input  wire                    we_i,
   input  sysctl_pkg::reg_addr_t  adr_i,
   input  wire [`SYSCTL_DW-1:0]   dat_i,
   output logic [`SYSCTL_DW-1:0]  dat_o,
   output logic                   ack_o,
   // register blocks
   wb_slave_if.master             rst_bus,
   wb_slave_if.master             cnt_bus,
   // high byte select for the counter
   output logic                   hi_sel_o
);

   import sysctl_pkg::*;

   logic      req;
   logic      id_stb;
   logic      id_ack;
   reg_addr_t sel_q;

   // qualified request from the master
   assign req = cyc_i && stb_i;

   // --------------------
   // strobe routing
   // --------------------

   assign rst_bus.stb = req && (adr_i == ADDR_RESET);
   // counter owns both byte addresses
   assign cnt_bus.stb = req && (adr_i == ADDR_CNT_LO || adr_i == ADDR_CNT_HI);
   assign id_stb      = req && (adr_i == ADDR_ID);

   // write enable and data go to every block
   assign rst_bus.we   = we_i;
   assign rst_bus.wdat = dat_i;
   assign cnt_bus.we   = we_i;
   assign cnt_bus.wdat = dat_i;

   // counter picks snapshot or low byte from this
   assign hi_sel_o = (adr_i == ADDR_CNT_HI);

   // --------------------
   // id register
   // --------------------

   // same ack rule as the blocks, one cycle after the strobe
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         id_ack <= 1'b0;
      end else begin
         id_ack <= id_stb && !id_ack;
      end
   end

   // --------------------
   // return path
   // --------------------

   // remember which register the pending access went to
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sel_q <= ADDR_RESET;
      end else if (req) begin
         sel_q <= adr_i;
      end
   end

   // only one block can ack at a time
   assign ack_o = rst_bus.ack || cnt_bus.ack || id_ack;

   // read data steered by the stored address
   always_comb begin
      dat_o = '0;
      if (ack_o) begin
         case (sel_q)
            ADDR_RESET:  dat_o = rst_bus.rdat;
            ADDR_ID:     dat_o = `SYSCTL_ID;
            ADDR_CNT_LO,
            ADDR_CNT_HI: dat_o = cnt_bus.rdat;
            default:     dat_o = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hw/reset_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sysctl_config.svh"

module reset_gen (
   input  wire        clk_i,
   input  wire        rst_i,
   // register bus slave
   wb_slave_if.slave  bus,
   // external hold, active low
   input  wire        reset_ni,
   // stretched reset pulse
   output logic       reset_o
);

   import sysctl_pkg::*;

   localparam int N = `SYSCTL_RESET_CYCLES;

   logic         accept;
   logic         arm;
   logic         latch_q;
   logic [N-1:0] stages_q;

   // --------------------
   // bus handshake
   // --------------------

   // first cycle of a strobe, also the edge that raises ack
   assign accept = bus.stb && !bus.ack;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         bus.ack <= 1'b0;
      end else begin
         bus.ack <= accept;
      end
   end

   // reset state in the arming bit, upper bits zero
   always_comb begin
      bus.rdat            = '0;
      bus.rdat[RESET_BIT] = reset_o;
   end

   // --------------------
   // reset latch
   // --------------------

   // write with the arming bit set
   assign arm = accept && bus.we && bus.wdat[RESET_BIT];

   // once set, only a high reset_ni releases it
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         latch_q <= 1'b0;
      end else if (latch_q) begin
         latch_q <= !reset_ni;
      end else begin
         latch_q <= arm;
      end
   end

   // --------------------
   // pulse stretcher
   // --------------------

   // latch shifted through N stages, output is their OR
   // registered, so reset_o rises two edges after the write
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         stages_q <= '0;
         reset_o  <= 1'b0;
      end else begin
         stages_q <= {stages_q[N-2:0], latch_q};
         reset_o  <= |stages_q;
      end
   end

endmodule

`default_nettype wire

// ==== hw/cycle_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sysctl_config.svh"

module cycle_counter (
   input  wire        clk_i,
   input  wire        rst_i,
   // register bus slave
   wb_slave_if.slave  bus,
   // high byte address selected
   input  wire        hi_sel_i
);

   import sysctl_pkg::*;

   localparam int DW  = `SYSCTL_DW;
   // width of the upper part held by the snapshot
   localparam int HIW = CNT_W - DW;

   logic             accept;
   logic             clr;
   logic             lo_rd;
   logic [CNT_W-1:0] count_q;
   logic [HIW-1:0]   snap_q;
   logic [DW-1:0]    rdat_q;

   // --------------------
   // bus handshake
   // --------------------

   // strobe seen for the first time
   assign accept = bus.stb && !bus.ack;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         bus.ack <= 1'b0;
      end else begin
         bus.ack <= accept;
      end
   end

   // any write clears, either byte address
   assign clr   = accept && bus.we;
   // low byte read, triggers the snapshot
   assign lo_rd = accept && !bus.we && !hi_sel_i;

   // --------------------
   // counter
   // --------------------

   // free-running, wraps at 16 bits
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         count_q <= '0;
      end else if (clr) begin
         count_q <= '0;
      end else begin
         count_q <= count_q + 1'b1;
      end
   end

   // --------------------
   // snapshot and read data
   // --------------------

   // upper byte frozen with the low byte read
   // keeps the two halves of one value together
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         snap_q <= '0;
      end else if (lo_rd) begin
         snap_q <= count_q[CNT_W-1:DW];
      end
   end

   // read byte captured on the accepting edge
   // valid in the ack cycle
   always_ff @(posedge clk_i) begin
      if (accept) begin
         rdat_q <= hi_sel_i ? snap_q : count_q[DW-1:0];
      end
   end

   assign bus.rdat = rdat_q;

endmodule

`default_nettype wire

// ==== hw/sysctl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sysctl_config.svh"

module sysctl_top (
   input  wire                    clk_i,
   input  wire                    rst_i,
   // bus from the master
   input  wire                    cyc_i,
   input  wire                    stb_i,
   input  wire                    we_i,
   input  wire [1:0]              adr_i,
   input  wire [`SYSCTL_DW-1:0]   dat_i,
   output logic [`SYSCTL_DW-1:0]  dat_o,
   output logic                   ack_o,
   // external reset hold and generated reset
   input  wire                    reset_ni,
   output logic                   reset_o
);

   import sysctl_pkg::*;

   // counter high byte select
   logic hi_sel;

   // one bundle per register block
   wb_slave_if rst_bus ();
   wb_slave_if cnt_bus ();

   // --------------------
   // address decode
   // --------------------

   sysctl_decoder u_decoder (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .cyc_i    (cyc_i),
      .stb_i    (stb_i),
      .we_i     (we_i),
      .adr_i    (reg_addr_t'(adr_i)),
      .dat_i    (dat_i),
      .dat_o    (dat_o),
      .ack_o    (ack_o),
      .rst_bus  (rst_bus.master),
      .cnt_bus  (cnt_bus.master),
      .hi_sel_o (hi_sel)
   );

   // --------------------
   // register blocks
   // --------------------

   reset_gen u_reset_gen (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .bus      (rst_bus.slave),
      .reset_ni (reset_ni),
      .reset_o  (reset_o)
   );

   cycle_counter u_cycle_counter (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .bus      (cnt_bus.slave),
      .hi_sel_i (hi_sel)
   );

endmodule

`default_nettype wire

// ==== sim/sysctl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sysctl_config.svh"

module sysctl_tb;

   import sysctl_pkg::*;

   localparam int DW = `SYSCTL_DW;
   localparam int N  = `SYSCTL_RESET_CYCLES;
   // write data that arms the reset generator
   localparam logic [DW-1:0] ARM_DATA = DW'(1 << RESET_BIT);

   logic          clk_i;
   logic          rst_i;
   logic          cyc_i;
   logic          stb_i;
   logic          we_i;
   logic [1:0]    adr_i;
   logic [DW-1:0] dat_i;
   logic [DW-1:0] dat_o;
   logic          ack_o;
   logic          reset_ni;
   logic          reset_o;

   // edges seen since time zero
   int          cycle_no = 0;
   // cycle of the last ack_o seen by a bus task
   int          last_ack;
   // ack cycle of the write that cleared the counter
   int          clear_ack;
   int          test_errs = 0;
   int          test_no = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;
   logic [31:0] lfsr_q = 32'h7f3c;

   sysctl_top DUT (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .cyc_i    (cyc_i),
      .stb_i    (stb_i),
      .we_i     (we_i),
      .adr_i    (adr_i),
      .dat_i    (dat_i),
      .dat_o    (dat_o),
      .ack_o    (ack_o),
      .reset_ni (reset_ni),
      .reset_o  (reset_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycle_no <= cycle_no + 1;
   end

   // --------------------
   // helpers
   // --------------------

   // galois step with taps 32 22 2 1
   function automatic logic lfsr_step();
      logic out;
      out    = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (out) begin
         lfsr_q = lfsr_q ^ 32'h8020_0003;
      end
      return out;
   endfunction

   // one lfsr step per bit
   function automatic int rand_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         v = (v << 1) | int'(lfsr_step());
      end
      return v;
   endfunction

   // low read shows the count one cycle before its ack
   // zero loaded at the clear ack
   function automatic logic [15:0] model_count(input int ack_cycle);
      return 16'(ack_cycle - clear_ack - 1);
   endfunction

   task automatic compare_value(input int got, input int exp, input string what);
      assert (got == exp) else begin
         $display("ERR %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
         test_errs++;
      end
   endtask

   task automatic require(input logic cond, input string what);
      assert (cond) else begin
         $display("ERR %0t: %s", $time, what);
         test_errs++;
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timeout: gave up waiting for %s", what);
      test_errs++;
   endtask

   task automatic finish_test(input string name);
      test_no++;
      if (test_errs == 0) begin
         tests_passed++;
         $display("test %0d %s: passed", test_no, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d error(s)", test_no, name, test_errs);
      end
      test_errs = 0;
   endtask

   // inputs change 1 ns after the edge
   task automatic step_cycle();
      @(posedge clk_i);
      #1;
   endtask

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         step_cycle();
      end
   endtask

   // single access with ack expected on the first edge
   // strobe then drops for one idle cycle before the next transfer
   task automatic bus_access(input logic write, input logic [1:0] adr,
                             input logic [DW-1:0] wdat, output logic [DW-1:0] rdat);
      int waited;
      cyc_i  = 1'b1;
      stb_i  = 1'b1;
      we_i   = write;
      adr_i  = adr;
      dat_i  = wdat;
      waited = 0;
      rdat   = '0;
      do begin
         step_cycle();
         waited++;
      end while (!ack_o && waited < 8);
      if (!ack_o) begin
         report_timeout("ack_o of a bus access");
      end else begin
         require(waited == 1, "ack_o not one cycle after the strobe");
         rdat     = dat_o;
         last_ack = cycle_no;
      end
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
      step_cycle();
   endtask

   task automatic bus_write(input logic [1:0] adr, input logic [DW-1:0] wdat);
      logic [DW-1:0] unused;
      bus_access(1'b1, adr, wdat, unused);
   endtask

   task automatic bus_read(input logic [1:0] adr, output logic [DW-1:0] rdat);
      bus_access(1'b0, adr, '0, rdat);
   endtask

   task automatic wait_reset_level(input logic level, input int limit);
      int waited;
      waited = 0;
      while (reset_o !== level && waited < limit) begin
         step_cycle();
         waited++;
      end
      if (reset_o !== level) begin
         report_timeout("reset_o to change level");
      end
   endtask

   // --------------------
   // test sequence
   // --------------------

   initial begin
      logic [DW-1:0] rd;
      logic [DW-1:0] hi;
      logic [15:0]   exp_cnt;
      logic [DW-1:0] snap;
      logic [1:0]    adr;
      int            mark;
      int            hold;
      int            start;
      rst_i    = 1'b1;
      cyc_i    = 1'b0;
      stb_i    = 1'b0;
      we_i     = 1'b0;
      adr_i    = '0;
      dat_i    = '0;
      reset_ni = 1'b1;
      repeat (5) @(posedge clk_i);
      #1;
      rst_i = 1'b0;

      // state after reset and id read
      require(reset_o == 1'b0, "reset_o high after reset");
      require(ack_o == 1'b0, "ack_o high after reset");
      bus_read(ADDR_ID, rd);
      compare_value(rd, `SYSCTL_ID, "id register");
      finish_test("after reset");

      // pulse rises two edges after the accepting edge
      // and lasts N cycles
      bus_write(ADDR_RESET, ARM_DATA);
      mark = last_ack;
      wait_reset_level(1'b1, 8);
      compare_value(cycle_no - mark, 2, "reset_o rise delay");
      mark = cycle_no;
      wait_reset_level(1'b0, N + 8);
      compare_value(cycle_no - mark, N, "reset pulse width");
      bus_write(ADDR_RESET, ARM_DATA);
      wait_reset_level(1'b1, 8);
      bus_read(ADDR_RESET, rd);
      compare_value(rd, 1, "reset state during the pulse");
      wait_reset_level(1'b0, N + 8);
      bus_read(ADDR_RESET, rd);
      compare_value(rd, 0, "reset state after the pulse");
      // arming bit clear
      bus_write(ADDR_RESET, DW'(rand_bits(DW)) & ~ARM_DATA);
      for (int i = 0; i < N + 4; i++) begin
         require(reset_o == 1'b0, "reset_o raised by a write without the arming bit");
         step_cycle();
      end
      finish_test("reset pulse");

      // latch held by a low reset_ni
      hold     = 5 + rand_bits(4);
      reset_ni = 1'b0;
      bus_write(ADDR_RESET, ARM_DATA);
      for (int i = 1; i <= hold; i++) begin
         step_cycle();
         if (i >= 2) begin
            require(reset_o == 1'b1, "reset_o low while reset_ni held low");
         end
      end
      reset_ni = 1'b1;
      step_cycle();
      mark = cycle_no;
      wait_reset_level(1'b0, N + 8);
      compare_value(cycle_no - mark, N + 1, "reset_o fall after release");
      // low reset_ni alone with nothing armed
      reset_ni = 1'b0;
      hold     = 5 + rand_bits(4);
      for (int i = 0; i < hold; i++) begin
         step_cycle();
         require(reset_o == 1'b0, "reset_o raised by reset_ni alone");
      end
      reset_ni = 1'b1;
      finish_test("external hold");

      // clear then low and high read back to back
      bus_write(ADDR_CNT_LO, DW'(rand_bits(DW)));
      clear_ack = last_ack;
      bus_read(ADDR_CNT_LO, rd);
      exp_cnt = model_count(last_ack);
      bus_read(ADDR_CNT_HI, hi);
      compare_value({hi, rd}, exp_cnt, "count after clear");
      finish_test("counter clear");

      // random gaps long enough to carry into the high byte
      // long wait before the high read so a live high byte would differ
      for (int k = 0; k < 16; k++) begin
         idle_cycles(rand_bits(7));
         bus_read(ADDR_CNT_LO, rd);
         exp_cnt = model_count(last_ack);
         snap    = exp_cnt[15:8];
         idle_cycles(rand_bits(9));
         bus_read(ADDR_CNT_HI, hi);
         compare_value({hi, rd}, exp_cnt, "16-bit count through the snapshot");
      end
      finish_test("snapshot consistency");

      // strobe held 4 cycles on every address from a random start
      start = rand_bits(2);
      for (int r = 0; r < 4; r++) begin
         adr   = 2'(start + r);
         cyc_i = 1'b1;
         stb_i = 1'b1;
         we_i  = 1'b0;
         adr_i = adr;
         for (int i = 0; i < 4; i++) begin
            require(ack_o == (i % 2 == 1), "held strobe ack pattern");
            if (ack_o) begin
               case (adr)
                  ADDR_RESET: compare_value(dat_o, 0, "held read of reset state");
                  ADDR_ID:    compare_value(dat_o, `SYSCTL_ID, "held read of id");
                  ADDR_CNT_LO: begin
                     exp_cnt = model_count(cycle_no);
                     snap    = exp_cnt[15:8];
                     compare_value(dat_o, exp_cnt[7:0], "held read of count low byte");
                  end
                  default:    compare_value(dat_o, snap, "held read of snapshot");
               endcase
            end
            step_cycle();
         end
         cyc_i = 1'b0;
         stb_i = 1'b0;
         idle_cycles(1 + rand_bits(2));
      end
      finish_test("held strobe");

      $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+common
common/sysctl_pkg.sv
common/wb_slave_if.sv
hw/sysctl_decoder.sv
hw/reset_gen.sv
hw/cycle_counter.sv
hw/sysctl_top.sv
sim/sysctl_tb.sv

// ==== Makefile ====
# Verilator build and run of the sysctl testbench

BIN = obj_dir/sysctl_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module sysctl_tb -o sysctl_tb

run: compile
	./$(BIN) | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
